// File: project.f
+incdir+common
common/ex_pkg.sv
design/instr_decoder.sv
alu/alu_execute.sv
design/result_stage.sv
design/ex_pipeline_top.sv
dv/ex_pipeline_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = ex_pipeline_tb
FILELIST = project.f
OBJ_DIR  = obj_dir
PASS_MSG = Done: no errors

.PHONY: sim clean

# Build and run, pass only if the pass line shows up in the output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/ex_pipeline_tb.sv
`timescale 1ns/100ps

module ex_pipeline_tb
    import ex_pkg::*;
();

    localparam int    CLK_PERIOD      = 20;
    localparam int    RESET_CYCLES    = 8;
    localparam int    CYCLES_PER_CASE = 40;
    // Every request in the table runs at this pc
    localparam xlen_t PC_BASE         = 32'h00000400;

    // One table row holds the request and its expected result
    typedef struct packed {
        ex_req_s    req;
        ex_result_s exp;
    } case_s;

    logic        i_clk;
    logic        i_reset;
    logic        i_req_valid;
    ex_req_s     i_req;
    logic        o_req_ready;
    logic        i_result_ready = 1'b1;
    logic        o_result_valid;
    ex_result_s  o_result;

    case_s       cases[$];
    // Results still owed by the DUT in request order
    ex_result_s  exp_q[$];
    logic        table_loaded = 1'b0;
    logic [15:0] lfsr_state   = 16'd60;

    int n_mismatch = 0;
    int n_other    = 0;
    int n_checked  = 0;

    ex_pipeline_top u_ex_pipeline_top (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_req_valid    (i_req_valid),
        .i_req          (i_req),
        .o_req_ready    (o_req_ready),
        .i_result_ready (i_result_ready),
        .o_result_valid (o_result_valid),
        .o_result       (o_result)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    ////////////////////////////////////////
    // Random back-pressure
    ////////////////////////////////////////

    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    // One LFSR step per cycle drives the ready from its low bit
    always @(posedge i_clk) begin
        if (i_reset) begin
            i_result_ready <= 1'b1;
        end else begin
            lfsr_state = lfsr_next(lfsr_state);
            i_result_ready <= lfsr_state[0];
        end
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_word(input string name, input xlen_t got, input xlen_t want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, want);
            n_mismatch++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, name, got, want);
            n_mismatch++;
        end
    endtask

    task automatic check_be(input string name, input byte_en_t got, input byte_en_t want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, name, got, want);
            n_mismatch++;
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, name, got, want);
            n_mismatch++;
        end
    endtask

    // Fields behind a clear enable carry no meaning and are skipped
    // A zero redirect_pc in a row leaves the target unchecked
    task automatic compare_result(input ex_result_s got, input ex_result_s want);
        check_flag("wb_en", got.wb_en, want.wb_en);
        if (want.wb_en) begin
            check_idx("wb_rd", got.wb_rd, want.wb_rd);
            check_word("wb_data", got.wb_data, want.wb_data);
        end
        check_flag("redirect", got.redirect, want.redirect);
        if (want.redirect || want.redirect_pc != '0) begin
            check_word("redirect_pc", got.redirect_pc, want.redirect_pc);
        end
        check_flag("mem_valid", got.mem_valid, want.mem_valid);
        check_flag("mem_we", got.mem_we, want.mem_we);
        check_be("mem_be", got.mem_be, want.mem_be);
        if (want.mem_valid) begin
            check_word("mem_addr", got.mem_addr, want.mem_addr);
        end
        if (want.mem_we) begin
            check_word("mem_wdata", got.mem_wdata, want.mem_wdata);
        end
        check_flag("illegal", got.illegal, want.illegal);
    endtask

    ////////////////////////////////////////
    // Table rows
    ////////////////////////////////////////

    task automatic append_case(input xlen_t instr, input xlen_t rs1, input xlen_t rs2,
                               input ex_result_s want);
        case_s row;
        row.req = '{instr: instr, pc: PC_BASE, rs1_val: rs1, rs2_val: rs2};
        row.exp = want;
        cases.push_back(row);
    endtask

    // ALU and upper immediate rows
    task automatic write_back_case(input xlen_t instr, input xlen_t rs1, input xlen_t rs2,
                                   input logic wb_en, input reg_idx_t rd, input xlen_t data);
        ex_result_s want;
        want         = '0;
        want.wb_en   = wb_en;
        want.wb_rd   = rd;
        want.wb_data = data;
        append_case(instr, rs1, rs2, want);
    endtask

    task automatic branch_case(input xlen_t instr, input xlen_t rs1, input xlen_t rs2,
                               input logic taken, input xlen_t target);
        ex_result_s want;
        want             = '0;
        want.redirect    = taken;
        want.redirect_pc = target;
        append_case(instr, rs1, rs2, want);
    endtask

    // Jumps always link and always redirect
    task automatic jump_case(input xlen_t instr, input xlen_t rs1, input reg_idx_t rd,
                             input xlen_t link, input xlen_t target);
        ex_result_s want;
        want             = '0;
        want.wb_en       = 1'b1;
        want.wb_rd       = rd;
        want.wb_data     = link;
        want.redirect    = 1'b1;
        want.redirect_pc = target;
        append_case(instr, rs1, 32'h0, want);
    endtask

    task automatic memory_case(input xlen_t instr, input xlen_t rs1, input xlen_t rs2,
                               input logic we, input xlen_t addr, input byte_en_t be,
                               input xlen_t wdata);
        ex_result_s want;
        want           = '0;
        want.mem_valid = 1'b1;
        want.mem_we    = we;
        want.mem_addr  = addr;
        want.mem_be    = be;
        want.mem_wdata = wdata;
        append_case(instr, rs1, rs2, want);
    endtask

    task automatic illegal_case(input xlen_t instr);
        ex_result_s want;
        want         = '0;
        want.illegal = 1'b1;
        append_case(instr, 32'h0, 32'h0, want);
    endtask

    task automatic load_table();
        // Register forms writing x3
        write_back_case(32'h002081B3, 32'h7FFFFFFF, 32'h00000001, 1'b1, 5'd3, 32'h80000000);
        write_back_case(32'h402081B3, 32'h00000005, 32'h00000007, 1'b1, 5'd3, 32'hFFFFFFFE);
        write_back_case(32'h0020A1B3, 32'hFFFFFFFF, 32'h00000001, 1'b1, 5'd3, 32'h00000001);
        write_back_case(32'h0020B1B3, 32'hFFFFFFFF, 32'h00000001, 1'b1, 5'd3, 32'h00000000);
        write_back_case(32'h0020C1B3, 32'hF0F01234, 32'h0FF0FF00, 1'b1, 5'd3, 32'hFF00ED34);
        write_back_case(32'h0020E1B3, 32'hF0F01234, 32'h0FF0FF00, 1'b1, 5'd3, 32'hFFF0FF34);
        write_back_case(32'h0020F1B3, 32'hF0F01234, 32'h0FF0FF00, 1'b1, 5'd3, 32'h00F01200);
        // Shift by 31 with the upper rs2 bits ignored
        write_back_case(32'h002091B3, 32'h00000003, 32'h0000003F, 1'b1, 5'd3, 32'h80000000);
        write_back_case(32'h0020D1B3, 32'h80000000, 32'h0000003F, 1'b1, 5'd3, 32'h00000001);
        write_back_case(32'h4020D1B3, 32'h80000000, 32'h0000003F, 1'b1, 5'd3, 32'hFFFFFFFF);
        // ADD to x0
        write_back_case(32'h00208033, 32'h00000001, 32'h00000002, 1'b0, 5'd0, 32'h00000003);
        // ADDI -1, SLTIU -1 and SRAI 31
        write_back_case(32'hFFF08193, 32'h00000010, 32'h00000000, 1'b1, 5'd3, 32'h0000000F);
        write_back_case(32'hFFF0B193, 32'h00001000, 32'h00000000, 1'b1, 5'd3, 32'h00000001);
        write_back_case(32'h41F0D193, 32'h80000000, 32'h00000000, 1'b1, 5'd3, 32'hFFFFFFFF);
        // BEQ jumps back by 8 and the other branches forward by 16
        branch_case(32'hFE208CE3, 32'h00000005, 32'h00000005, 1'b1, 32'h000003F8);
        branch_case(32'h00208863, 32'hFFFFFFFF, 32'h00000001, 1'b0, 32'h00000404);
        branch_case(32'h00209863, 32'hFFFFFFFF, 32'h00000001, 1'b1, 32'h00000410);
        branch_case(32'h00209863, 32'h00000005, 32'h00000005, 1'b0, 32'h00000404);
        branch_case(32'h0020C863, 32'hFFFFFFFF, 32'h00000001, 1'b1, 32'h00000410);
        branch_case(32'h0020C863, 32'h00000001, 32'hFFFFFFFF, 1'b0, 32'h00000404);
        branch_case(32'h0020D863, 32'hFFFFFFFF, 32'h00000001, 1'b0, 32'h00000404);
        branch_case(32'h0020D863, 32'h00000001, 32'hFFFFFFFF, 1'b1, 32'h00000410);
        branch_case(32'h0020E863, 32'h00000001, 32'hFFFFFFFF, 1'b1, 32'h00000410);
        branch_case(32'h0020E863, 32'hFFFFFFFF, 32'h00000001, 1'b0, 32'h00000404);
        branch_case(32'h0020F863, 32'hFFFFFFFF, 32'h00000001, 1'b1, 32'h00000410);
        branch_case(32'h0020F863, 32'h00000001, 32'hFFFFFFFF, 1'b0, 32'h00000404);
        // JAL +256 and JALR x5+3 with bit 0 dropped
        jump_case(32'h100000EF, 32'h00000000, 5'd1, 32'h00000404, 32'h00000500);
        jump_case(32'h003280E7, 32'h00001000, 5'd1, 32'h00000404, 32'h00001002);
        // LUI and AUIPC
        write_back_case(32'hABCDE1B7, 32'h00000000, 32'h00000000, 1'b1, 5'd3, 32'hABCDE000);
        write_back_case(32'h12345197, 32'h00000000, 32'h00000000, 1'b1, 5'd3, 32'h12345400);
        // Loads LB +1, LB +3, LH +2 and LW +0
        memory_case(32'h00108183, 32'h00002000, 32'h123456A5, 1'b0, 32'h00002000, 4'b0010, 0);
        memory_case(32'h00308183, 32'h00002000, 32'h123456A5, 1'b0, 32'h00002000, 4'b1000, 0);
        memory_case(32'h00209183, 32'h00002000, 32'h123456A5, 1'b0, 32'h00002000, 4'b1100, 0);
        memory_case(32'h0000A183, 32'h00002000, 32'h123456A5, 1'b0, 32'h00002000, 4'b1111, 0);
        // SB at all four lanes
        memory_case(32'h00208023, 32'h00002000, 32'h123456A5, 1'b1, 32'h00002000, 4'b0001,
                    32'hA5A5A5A5);
        memory_case(32'h002080A3, 32'h00002000, 32'h123456A5, 1'b1, 32'h00002000, 4'b0010,
                    32'hA5A5A5A5);
        memory_case(32'h00208123, 32'h00002000, 32'h123456A5, 1'b1, 32'h00002000, 4'b0100,
                    32'hA5A5A5A5);
        memory_case(32'h002081A3, 32'h00002000, 32'h123456A5, 1'b1, 32'h00002000, 4'b1000,
                    32'hA5A5A5A5);
        // SH at both halves and SW at 0x2003 + 1
        memory_case(32'h00209023, 32'h00002000, 32'h123456A5, 1'b1, 32'h00002000, 4'b0011,
                    32'h56A556A5);
        memory_case(32'h00209123, 32'h00002000, 32'h123456A5, 1'b1, 32'h00002000, 4'b1100,
                    32'h56A556A5);
        memory_case(32'h0020A0A3, 32'h00002003, 32'h123456A5, 1'b1, 32'h00002004, 4'b1111,
                    32'h123456A5);
        // ECALL, FENCE and branch funct3 010
        illegal_case(32'h00000073);
        illegal_case(32'h0000000F);
        illegal_case(32'h0020A863);
    endtask

    ////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////

    // Sampled mid-cycle since a transfer lands on the next rising edge
    always @(negedge i_clk) begin
        if (!i_reset) begin
            check_flag("o_req_ready", o_req_ready, !(o_result_valid && !i_result_ready));
            if (o_result_valid && i_result_ready) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR at %0t ns: result accepted with none outstanding", $time);
                    n_other++;
                end else begin
                    compare_result(o_result, exp_q.pop_front());
                    n_checked++;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Driver
    ////////////////////////////////////////

    initial begin
        i_reset     <= 1'b1;
        i_req_valid <= 1'b0;
        i_req       <= '0;
        load_table();
        table_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        check_flag("o_result_valid", o_result_valid, 1'b0);
        @(posedge i_clk);

        // Hold each request until the DUT is ready for it
        foreach (cases[i]) begin
            i_req_valid <= 1'b1;
            i_req       <= cases[i].req;
            @(negedge i_clk);
            while (!o_req_ready) begin
                @(negedge i_clk);
            end
            exp_q.push_back(cases[i].exp);
            @(posedge i_clk);
        end
        i_req_valid <= 1'b0;
        i_req       <= '0;

        // Drain and wait a few idle cycles to catch extra results
        while (exp_q.size() != 0) begin
            @(negedge i_clk);
        end
        repeat (6) @(negedge i_clk);

        if (n_checked != cases.size()) begin
            $display("ERROR: %0d results seen for %0d requests", n_checked, cases.size());
            n_other++;
        end
        $display("Summary: %0d results checked, %0d mismatches, %0d other errors",
                 n_checked, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (table_loaded);
        repeat (cases.size() * CYCLES_PER_CASE + RESET_CYCLES) @(posedge i_clk);
        $display("TIMEOUT: %0d results still outstanding, run stopped", exp_q.size());
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: design/ex_pipeline_top.sv
`timescale 1ns/100ps

module ex_pipeline_top import ex_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_req_valid,
    input  ex_req_s    i_req,
    output logic       o_req_ready,
    input  logic       i_result_ready,
    output logic       o_result_valid,
    output ex_result_s o_result
);

    // One stall for all stages, bubbles are kept
    logic     stall;

    logic     dec_valid;
    dec_out_s dec;
    logic     exe_valid;
    exe_out_s exe;

    assign stall       = o_result_valid && !i_result_ready;
    assign o_req_ready = !stall;

    instr_decoder u_instr_decoder (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_stall     (stall),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .o_valid     (dec_valid),
        .o_dec       (dec)
    );

    alu_execute u_alu_execute (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_stall (stall),
        .i_valid (dec_valid),
        .i_dec   (dec),
        .o_valid (exe_valid),
        .o_exe   (exe)
    );

    result_stage u_result_stage (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_stall        (stall),
        .i_valid        (exe_valid),
        .i_exe          (exe),
        .o_result_valid (o_result_valid),
        .o_result       (o_result)
    );

endmodule

// File: design/result_stage.sv
`timescale 1ns/100ps
`include "ex_defines.svh"

module result_stage import ex_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_stall,
    input  logic       i_valid,
    input  exe_out_s   i_exe,
    output logic       o_result_valid,
    output ex_result_s o_result
);

    control_s   ctrl;
    xlen_t      addr;
    xlen_t      sdata;
    byte_en_t   be;
    xlen_t      wdata;
    ex_result_s result_next;

    assign ctrl  = i_exe.ctrl;
    assign addr  = i_exe.result;
    assign sdata = i_exe.store_data;

    ////////////////////////////////////////
    // Byte enables and store lanes
    ////////////////////////////////////////

    always_comb begin
        // Access size from fcs bits [1:0], sign bit [2] only matters for loads
        case (ctrl.fcs_opcode[1:0])
            2'b00: begin
                be    = 4'b0001 << addr[1:0];
                wdata = {4{sdata[7:0]}};
            end
            2'b01: begin
                // Half lands in the lower or upper half of the word
                be    = addr[1] ? 4'b1100 : 4'b0011;
                wdata = {2{sdata[15:0]}};
            end
            default: begin
                be    = 4'b1111;
                wdata = sdata;
            end
        endcase
    end

    always_comb begin
        result_next = '0;
        // Loads write back later in the memory stage
        result_next.wb_en       = i_valid && ctrl.writes_rd && !ctrl.mem;
        result_next.wb_rd       = ctrl.rd;
        result_next.wb_data     = i_exe.result;
        result_next.redirect    = i_valid && i_exe.taken &&
                                  (ctrl.cond_branch || ctrl.uncond_branch);
        result_next.redirect_pc = i_exe.target_pc;
        result_next.mem_valid   = i_valid && ctrl.mem;
        result_next.mem_we      = i_valid && ctrl.mem && ctrl.is_store;
        result_next.mem_addr    = {addr[31:2], 2'b00};
        result_next.mem_be      = ctrl.mem ? be : 4'b0000;
        result_next.mem_wdata   = ctrl.is_store ? wdata : '0;
        result_next.illegal     = ctrl.illegal;
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_result_valid       <= 1'b0;
            o_result             <= '0;
            o_result.redirect_pc <= `EX_RESET_VECTOR;
        end else if (!i_stall) begin
            o_result_valid <= i_valid;
            o_result       <= result_next;
        end
    end

    // A held result must not change until the caller takes it
    a_hold_stable: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (o_result_valid && i_stall) |=> (o_result_valid && $stable(o_result))
    );

endmodule

// File: alu/alu_execute.sv
`timescale 1ns/100ps

module alu_execute import ex_pkg::*; (
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_stall,
    input  logic     i_valid,
    input  dec_out_s i_dec,
    output logic     o_valid,
    output exe_out_s o_exe
);

    control_s ctrl;
    xlen_t    rs1;
    xlen_t    rs2;
    xlen_t    imm;
    xlen_t    pc;

    // Second ALU operand and shift amount
    xlen_t      op2;
    logic [4:0] shamt;

    xlen_t    alu_res;
    logic     cmp_taken;
    xlen_t    pc_plus_4;
    xlen_t    pc_plus_imm;
    xlen_t    rs1_plus_imm;

    xlen_t    result;
    logic     taken;
    xlen_t    target_pc;
    exe_out_s exe_next;

    assign ctrl = i_dec.ctrl;
    assign rs1  = i_dec.rs1_val;
    assign rs2  = i_dec.rs2_val;
    assign imm  = i_dec.imm;
    assign pc   = i_dec.pc;

    assign op2   = ctrl.alu_imm ? imm : rs2;
    assign shamt = op2[4:0];

    // Shared adders
    assign pc_plus_4    = pc + 32'd4;
    assign pc_plus_imm  = pc + imm;
    assign rs1_plus_imm = rs1 + imm;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        case (alu_op_e'(ctrl.fcs_opcode))
            OP_ADD_SUB: begin
                // iop only set for SUB, ADDI never inverts
                alu_res = ctrl.iop ? rs1 - op2 : rs1 + op2;
            end
            OP_SLT:  alu_res = {31'b0, $signed(rs1) < $signed(op2)};
            // Full width unsigned compare, immediate already sign-extended
            OP_SLTU: alu_res = {31'b0, rs1 < op2};
            OP_XOR:  alu_res = rs1 ^ op2;
            OP_OR:   alu_res = rs1 | op2;
            OP_AND:  alu_res = rs1 & op2;
            OP_SLL:  alu_res = rs1 << shamt;
            OP_SRL_SRA: begin
                // Arithmetic shift keeps the sign of rs1
                if (ctrl.iop) begin
                    alu_res = $signed(rs1) >>> shamt;
                end else begin
                    alu_res = rs1 >> shamt;
                end
            end
            default: alu_res = '0;
        endcase
    end

    ////////////////////////////////////////
    // Branch compare
    ////////////////////////////////////////

    always_comb begin
        case (ctrl.fcs_opcode)
            // BEQ
            3'b000: cmp_taken = (rs1 == rs2);
            // BNE
            3'b001: cmp_taken = (rs1 != rs2);
            // BLT
            3'b100: cmp_taken = $signed(rs1) < $signed(rs2);
            // BGE
            3'b101: cmp_taken = $signed(rs1) >= $signed(rs2);
            // BLTU
            3'b110: cmp_taken = rs1 < rs2;
            // BGEU
            3'b111: cmp_taken = rs1 >= rs2;
            default: cmp_taken = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // Result select per category
    ////////////////////////////////////////

    always_comb begin
        result    = '0;
        taken     = 1'b0;
        target_pc = pc_plus_4;
        if (ctrl.alu_imm || ctrl.alu_reg) begin
            result = alu_res;
        end else if (ctrl.cond_branch) begin
            taken     = cmp_taken;
            target_pc = cmp_taken ? pc_plus_imm : pc_plus_4;
        end else if (ctrl.uncond_branch) begin
            // Link address goes to rd for both jumps
            result = pc_plus_4;
            taken  = 1'b1;
            // JALR is fcs 011, target is rs1 relative with bit 0 dropped
            if (ctrl.fcs_opcode == 3'b011) begin
                target_pc = {rs1_plus_imm[31:1], 1'b0};
            end else begin
                target_pc = pc_plus_imm;
            end
        end else if (ctrl.load_upper_imm) begin
            // LUI when iop set, AUIPC otherwise
            result = ctrl.iop ? imm : pc_plus_imm;
        end else if (ctrl.mem) begin
            // Effective address for loads and stores
            result = rs1_plus_imm;
        end
    end

    assign exe_next = '{ctrl: ctrl, result: result, store_data: rs2,
                        taken: taken, target_pc: target_pc};

    ////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else if (!i_stall) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_exe <= exe_next;
        end
    end

    // Decoder must hand over at most one category per instruction
    a_one_category: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_valid |-> $onehot0({ctrl.load_upper_imm, ctrl.uncond_branch, ctrl.cond_branch,
                              ctrl.mem, ctrl.alu_imm, ctrl.alu_reg})
    );

endmodule

// File: design/instr_decoder.sv
`timescale 1ns/100ps
`include "ex_defines.svh"

module instr_decoder import ex_pkg::*; (
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_stall,
    input  logic     i_req_valid,
    input  ex_req_s  i_req,
    output logic     o_valid,
    output dec_out_s o_dec
);

    // Instruction fields
    logic [6:0] opcode;
    logic [6:0] funct7;
    fcs_t       funct3;
    reg_idx_t   rd;
    xlen_t      instr;

    control_s   ctrl;
    xlen_t      imm;
    dec_out_s   dec_next;

    assign instr  = i_req.instr;
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    ////////////////////////////////////////
    // Control and immediate decode
    ////////////////////////////////////////

    always_comb begin
        ctrl            = '0;
        imm             = '0;
        ctrl.fcs_opcode = funct3;
        ctrl.rd         = rd;
        case (opcode)
            `EX_OP_LUI: begin
                // Upper immediate, iop picks LUI over AUIPC
                ctrl.load_upper_imm = 1'b1;
                ctrl.iop            = 1'b1;
                ctrl.fcs_opcode     = 3'b000;
                ctrl.writes_rd      = 1'b1;
                imm                 = {instr[31:12], 12'b0};
            end
            `EX_OP_AUIPC: begin
                ctrl.load_upper_imm = 1'b1;
                ctrl.fcs_opcode     = 3'b000;
                ctrl.writes_rd      = 1'b1;
                imm                 = {instr[31:12], 12'b0};
            end
            `EX_OP_JAL: begin
                ctrl.uncond_branch = 1'b1;
                ctrl.fcs_opcode    = 3'b010;
                ctrl.writes_rd     = 1'b1;
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            `EX_OP_JALR: begin
                ctrl.uncond_branch = 1'b1;
                ctrl.fcs_opcode    = 3'b011;
                ctrl.writes_rd     = 1'b1;
                ctrl.illegal       = (funct3 != 3'b000);
                imm                = {{20{instr[31]}}, instr[31:20]};
            end
            `EX_OP_BRANCH: begin
                // funct3 010 and 011 are not assigned
                ctrl.cond_branch = 1'b1;
                ctrl.illegal     = (funct3[2:1] == 2'b01);
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            `EX_OP_LOAD: begin
                // LB LH LW LBU LHU
                ctrl.mem       = 1'b1;
                ctrl.writes_rd = 1'b1;
                ctrl.illegal   = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
                imm            = {{20{instr[31]}}, instr[31:20]};
            end
            `EX_OP_STORE: begin
                // SB SH SW only
                ctrl.mem      = 1'b1;
                ctrl.is_store = 1'b1;
                ctrl.iop      = 1'b1;
                ctrl.illegal  = funct3[2] || (funct3[1:0] == 2'b11);
                imm           = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            `EX_OP_IMM: begin
                ctrl.alu_imm   = 1'b1;
                ctrl.writes_rd = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:20]};
                // Shift immediates carry funct7, bit 30 selects SRAI
                if (funct3 == OP_SRL_SRA) begin
                    ctrl.iop     = instr[30];
                    ctrl.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end else if (funct3 == OP_SLL) begin
                    ctrl.illegal = (funct7 != 7'b0000000);
                end
            end
            `EX_OP_REG: begin
                ctrl.alu_reg   = 1'b1;
                ctrl.writes_rd = 1'b1;
                ctrl.iop       = instr[30];
                // Alternate funct7 only exists for SUB and SRA
                if (funct7 == 7'b0100000) begin
                    ctrl.illegal = (funct3 != OP_ADD_SUB) && (funct3 != OP_SRL_SRA);
                end else begin
                    ctrl.illegal = (funct7 != 7'b0000000);
                end
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase

        // Illegal encodings execute nothing
        if (ctrl.illegal) begin
            ctrl.load_upper_imm = 1'b0;
            ctrl.uncond_branch  = 1'b0;
            ctrl.cond_branch    = 1'b0;
            ctrl.mem            = 1'b0;
            ctrl.alu_imm        = 1'b0;
            ctrl.alu_reg        = 1'b0;
            ctrl.is_store       = 1'b0;
        end
        // x0 is never written
        ctrl.writes_rd = ctrl.writes_rd && !ctrl.illegal && (rd != 5'd0);
    end

    assign dec_next = '{ctrl: ctrl, imm: imm, pc: i_req.pc,
                        rs1_val: i_req.rs1_val, rs2_val: i_req.rs2_val};

    ////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else if (!i_stall) begin
            o_valid <= i_req_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_dec <= dec_next;
        end
    end

endmodule

// File: common/ex_pkg.sv
`include "ex_defines.svh"

package ex_pkg;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    // Data or address word
    typedef logic [`EX_XLEN-1:0] xlen_t;
    // Register file index
    typedef logic [4:0] reg_idx_t;
    // Operation select inside a category, funct3 in most cases
    typedef logic [2:0] fcs_t;
    // One enable per byte lane of a memory word
    typedef logic [3:0] byte_en_t;

    // ALU operation codes, same values as funct3 of the ALU opcodes
    typedef enum logic [2:0] {
        OP_ADD_SUB = 3'b000,
        OP_SLL     = 3'b001,
        OP_SLT     = 3'b010,
        OP_SLTU    = 3'b011,
        OP_XOR     = 3'b100,
        OP_SRL_SRA = 3'b101,
        OP_OR      = 3'b110,
        OP_AND     = 3'b111
    } alu_op_e;

    ////////////////////////////////////////
    // Pipeline structs
    ////////////////////////////////////////

    // Decoded control word, category flags are one-hot or all zero
    typedef struct packed {
        logic     load_upper_imm;
        logic     uncond_branch;
        logic     cond_branch;
        logic     mem;
        logic     alu_imm;
        logic     alu_reg;
        fcs_t     fcs_opcode;
        // SUB, SRA, SRAI, LUI and stores
        logic     iop;
        logic     is_store;
        logic     writes_rd;
        logic     illegal;
        reg_idx_t rd;
    } control_s;

    // Request from the caller, operands already read
    typedef struct packed {
        xlen_t instr;
        xlen_t pc;
        xlen_t rs1_val;
        xlen_t rs2_val;
    } ex_req_s;

    // Decode to execute
    typedef struct packed {
        control_s ctrl;
        xlen_t    imm;
        xlen_t    pc;
        xlen_t    rs1_val;
        xlen_t    rs2_val;
    } dec_out_s;

    // Execute to result
    typedef struct packed {
        control_s ctrl;
        xlen_t    result;
        xlen_t    store_data;
        logic     taken;
        xlen_t    target_pc;
    } exe_out_s;

    // Final result presented to the caller
    typedef struct packed {
        logic     wb_en;
        reg_idx_t wb_rd;
        xlen_t    wb_data;
        logic     redirect;
        xlen_t    redirect_pc;
        logic     mem_valid;
        logic     mem_we;
        xlen_t    mem_addr;
        byte_en_t mem_be;
        xlen_t    mem_wdata;
        logic     illegal;
    } ex_result_s;

endpackage

// File: common/ex_defines.svh
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Data and address width of the RV32I datapath
`define EX_XLEN 32

// Value of the held program counter after reset
`define EX_RESET_VECTOR 32'h0000_0000

////////////////////////////////////////
// Major opcodes, instruction bits [6:0]
////////////////////////////////////////

`define EX_OP_LUI    7'b0110111
`define EX_OP_AUIPC  7'b0010111
`define EX_OP_JAL    7'b1101111
`define EX_OP_JALR   7'b1100111
`define EX_OP_BRANCH 7'b1100011
`define EX_OP_LOAD   7'b0000011
`define EX_OP_STORE  7'b0100011
// Register-immediate ALU forms
`define EX_OP_IMM    7'b0010011
// Register-register ALU forms
`define EX_OP_REG    7'b0110011

`endif
